//--- rtl/proc_settings.svh
// processor sizing
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// data, pc and instruction width
`define PROC_WORD_W 16

// architectural registers
`define PROC_REG_CNT 8

// instruction memory depth in words
`define PROC_IMEM_WORDS 256

// data memory depth in words
`define PROC_DMEM_WORDS 256

`endif

//--- rtl/procIsaPkg.sv
// instruction set types
`default_nettype none
`include "proc_settings.svh"

package procIsaPkg;

   typedef logic [`PROC_WORD_W-1:0] word_t;
   typedef logic [$clog2(`PROC_REG_CNT)-1:0] regSel_t;
   typedef logic [$clog2(`PROC_IMEM_WORDS)-1:0] imemAddr_t;

   // 0xa..0xe are not assigned
   typedef enum logic [3:0] {
      opNop  = 4'h0,
      opAdd  = 4'h1,
      opSub  = 4'h2,
      opAnd  = 4'h3,
      opXor  = 4'h4,
      opAddi = 4'h5,
      opLdi  = 4'h6,
      opLd   = 4'h7,
      opSt   = 4'h8,
      opBeqz = 4'h9,
      opHalt = 4'hf
   } opcode_t;

   // instruction field layout
   localparam int opLsb = 12;
   localparam int rdLsb = 9;
   localparam int rsLsb = 6;
   localparam int rtLsb = 3;
   localparam int imm6W = 6;
   localparam int imm9W = 9;

   function automatic word_t sextImm6(word_t inst);
      return {{(`PROC_WORD_W-imm6W){inst[imm6W-1]}}, inst[imm6W-1:0]};
   endfunction

   function automatic word_t sextImm9(word_t inst);
      return {{(`PROC_WORD_W-imm9W){inst[imm9W-1]}}, inst[imm9W-1:0]};
   endfunction

endpackage

`default_nettype wire

//--- rtl/procPipePkg.sv
// pipeline control types
`default_nettype none

package procPipePkg;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluXor,
      aluPassB   // result is operand b
   } aluOp_t;

   // where the register write value comes from
   typedef enum logic [1:0] {
      wbAlu,
      wbMem,
      wbNone
   } wbSrc_t;

   // control bits carried down the pipe, upper bits spare
   typedef logic [7:0] pipeCtrl_t;

   localparam int ctrlRegWrite = 0;
   localparam int ctrlMemRead  = 1;
   localparam int ctrlMemWrite = 2;
   localparam int ctrlBranch   = 3;
   localparam int ctrlHalt     = 4;

endpackage

`default_nettype wire

//--- rtl/procStageIf.sv
// stage to stage buses
`default_nettype none

interface decExIf;
   import procIsaPkg::*;
   import procPipePkg::*;

   logic      valid;
   pipeCtrl_t ctrl;
   aluOp_t    aluOp;
   wbSrc_t    wbSrc;
   word_t     opA;
   word_t     opB;         // rt value or sign-extended immediate
   word_t     storeData;   // rd value, for ST and BEQZ
   word_t     pc;
   regSel_t   rd;

   modport src (output valid, ctrl, aluOp, wbSrc, opA, opB, storeData, pc, rd);
   modport dst (input valid, ctrl, aluOp, wbSrc, opA, opB, storeData, pc, rd);
endinterface

interface exMemIf;
   import procIsaPkg::*;
   import procPipePkg::*;

   logic      valid;
   pipeCtrl_t ctrl;
   wbSrc_t    wbSrc;
   word_t     aluResult;   // also the memory address
   word_t     storeData;
   regSel_t   rd;

   modport src (output valid, ctrl, wbSrc, aluResult, storeData, rd);
   modport dst (input valid, ctrl, wbSrc, aluResult, storeData, rd);
endinterface

`default_nettype wire

//--- rtl/fetchStage.sv
// fetch stage
`default_nettype none
`include "proc_settings.svh"

module fetchStage (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  logic                  progWrEn,
   input  procIsaPkg::imemAddr_t progAddr,
   input  procIsaPkg::word_t     progData,
   input  logic                  stall,
   input  logic                  halted,
   input  logic                  redirect,
   input  procIsaPkg::word_t     redirectPc,
   output logic                  ifValid,
   output procIsaPkg::word_t     ifInst,
   output procIsaPkg::word_t     ifPc
);
   import procIsaPkg::*;

   word_t     imem [`PROC_IMEM_WORDS];
   word_t     pc;
   imemAddr_t fetchIdx;

   // byte address, one word per instruction
   assign fetchIdx = pc[$bits(imemAddr_t):1];

   // program port is open even while running
   always_ff @(posedge clk) begin
      if (progWrEn) begin
         imem[progAddr] <= progData;
      end
   end

   assign ifValid = run && !halted;
   assign ifInst  = imem[fetchIdx];
   assign ifPc    = pc;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (redirect) begin
         pc <= redirectPc;          // taken branch wins over stall
      end else if (ifValid && !stall) begin
         pc <= pc + word_t'(2);
      end
   end

endmodule

`default_nettype wire

//--- rtl/decodeStage.sv
// decode stage, register file and hazard stall
`default_nettype none
`include "proc_settings.svh"

module decodeStage (
   input  logic                clk,
   input  logic                rst,
   input  logic                ifValid,
   input  procIsaPkg::word_t   ifInst,
   input  procIsaPkg::word_t   ifPc,
   input  logic                redirect,
   input  logic                wbEn,
   input  procIsaPkg::regSel_t wbReg,
   input  procIsaPkg::word_t   wbData,
   output logic                stall,
   output logic                err,
   decExIf.src                 decEx
);
   import procIsaPkg::*;
   import procPipePkg::*;

   logic      ifIdValid;
   word_t     ifIdInst;
   word_t     ifIdPc;
   word_t     regs [`PROC_REG_CNT];
   opcode_t   op;
   regSel_t   rd;
   regSel_t   rs;
   regSel_t   rt;
   pipeCtrl_t ctrl;
   aluOp_t    aluOp;
   wbSrc_t    wbSrc;
   logic      useRs;
   logic      useRt;
   logic      useRd;
   logic      immB;
   logic      illegal;
   word_t     immVal;
   word_t     rsVal;
   word_t     rtVal;
   word_t     rdVal;
   logic      idExIllegal;
   logic      exMemWr;     // copy of the EX/MEM write enable and target
   regSel_t   exMemRd;

   // a write in the same cycle is seen by the read
   function automatic word_t readReg(regSel_t r);
      return (wbEn && wbReg == r) ? wbData : regs[r];
   endfunction

   function automatic logic pendingWrite(regSel_t r);
      return (decEx.valid && decEx.ctrl[ctrlRegWrite] && decEx.rd == r) ||
             (exMemWr && exMemRd == r);
   endfunction

   always_ff @(posedge clk) begin
      if (rst || redirect) begin
         ifIdValid <= 1'b0;
      end else if (!stall) begin
         ifIdValid <= ifValid;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         ifIdInst <= ifInst;
         ifIdPc   <= ifPc;
      end
   end

   assign op = opcode_t'(ifIdInst[opLsb +: $bits(opcode_t)]);
   assign rd = ifIdInst[rdLsb +: $bits(regSel_t)];
   assign rs = ifIdInst[rsLsb +: $bits(regSel_t)];
   assign rt = ifIdInst[rtLsb +: $bits(regSel_t)];

   always_comb begin
      ctrl    = '0;
      aluOp   = aluAdd;
      wbSrc   = wbNone;
      useRs   = 1'b0;
      useRt   = 1'b0;
      useRd   = 1'b0;
      immB    = 1'b1;
      illegal = 1'b0;
      immVal  = sextImm6(ifIdInst);
      case (op)
         opAdd, opSub, opAnd, opXor: begin
            ctrl[ctrlRegWrite] = 1'b1;
            wbSrc = wbAlu;
            useRs = 1'b1;
            useRt = 1'b1;
            immB  = 1'b0;
            aluOp = (op == opSub) ? aluSub : (op == opAnd) ? aluAnd :
                    (op == opXor) ? aluXor : aluAdd;
         end
         opAddi: begin
            ctrl[ctrlRegWrite] = 1'b1;
            wbSrc = wbAlu;
            useRs = 1'b1;
         end
         opLdi: begin
            ctrl[ctrlRegWrite] = 1'b1;
            wbSrc  = wbAlu;
            aluOp  = aluPassB;
            immVal = sextImm9(ifIdInst);
         end
         opLd: begin
            ctrl[ctrlRegWrite] = 1'b1;
            ctrl[ctrlMemRead]  = 1'b1;
            wbSrc = wbMem;
            useRs = 1'b1;
         end
         opSt: begin
            ctrl[ctrlMemWrite] = 1'b1;
            useRs = 1'b1;
            useRd = 1'b1;     // store data
         end
         opBeqz: begin
            ctrl[ctrlBranch] = 1'b1;
            useRd  = 1'b1;    // tested for zero in execute
            immVal = sextImm9(ifIdInst);
         end
         opHalt: ctrl[ctrlHalt] = 1'b1;
         opNop: ;
         default: illegal = 1'b1;
      endcase
   end

   always_comb begin
      rsVal = readReg(rs);
      rtVal = readReg(rt);
      rdVal = readReg(rd);
   end

   // hold while an older instruction in ID/EX or EX/MEM still owes a source
   always_comb begin
      stall = 1'b0;
      if (ifIdValid && !redirect) begin
         stall = (useRs && pendingWrite(rs)) || (useRt && pendingWrite(rt)) ||
                 (useRd && pendingWrite(rd));
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         regs <= '{default: '0};
      end else if (wbEn) begin
         regs[wbReg] <= wbData;
      end
   end

   always_ff @(posedge clk) begin
      if (rst || redirect || stall) begin
         decEx.valid <= 1'b0;        // bubble
         decEx.ctrl  <= '0;
         idExIllegal <= 1'b0;
      end else begin
         decEx.valid <= ifIdValid;
         decEx.ctrl  <= ctrl;
         idExIllegal <= illegal;
      end
   end

   always_ff @(posedge clk) begin
      decEx.aluOp     <= aluOp;
      decEx.wbSrc     <= wbSrc;
      decEx.opA       <= rsVal;
      decEx.opB       <= immB ? immVal : rtVal;
      decEx.storeData <= rdVal;
      decEx.pc        <= ifIdPc;
      decEx.rd        <= rd;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         exMemWr <= 1'b0;
      end else begin
         exMemWr <= decEx.valid && decEx.ctrl[ctrlRegWrite];
      end
   end

   always_ff @(posedge clk) begin
      exMemRd <= decEx.rd;
   end

   assign err = decEx.valid && idExIllegal;

endmodule

`default_nettype wire

//--- rtl/executeStage.sv
// execute stage, ALU and branch resolution
`default_nettype none

module executeStage (
   input  logic              clk,
   input  logic              rst,
   decExIf.dst               decEx,
   exMemIf.src               exMem,
   output logic              redirect,
   output procIsaPkg::word_t redirectPc
);
   import procIsaPkg::*;
   import procPipePkg::*;

   word_t aluOut;

   always_comb begin
      case (decEx.aluOp)
         aluSub:   aluOut = decEx.opA - decEx.opB;
         aluAnd:   aluOut = decEx.opA & decEx.opB;
         aluXor:   aluOut = decEx.opA ^ decEx.opB;
         aluPassB: aluOut = decEx.opB;
         default:  aluOut = decEx.opA + decEx.opB;
      endcase
   end

   // BEQZ tests rd, carried as store data
   assign redirect = decEx.valid && decEx.ctrl[ctrlBranch] && (decEx.storeData == '0);

   // target is pc + 2 + 2*imm9
   assign redirectPc = decEx.pc + word_t'(2) + (decEx.opB << 1);

   always_ff @(posedge clk) begin
      if (rst) begin
         exMem.valid <= 1'b0;
         exMem.ctrl  <= '0;
      end else begin
         exMem.valid <= decEx.valid;
         exMem.ctrl  <= decEx.ctrl;
      end
   end

   always_ff @(posedge clk) begin
      exMem.wbSrc     <= decEx.wbSrc;
      exMem.aluResult <= aluOut;
      exMem.storeData <= decEx.storeData;
      exMem.rd        <= decEx.rd;
   end

endmodule

`default_nettype wire

//--- rtl/memWbStage.sv
// memory and writeback stage
`default_nettype none
`include "proc_settings.svh"

module memWbStage (
   input  logic                clk,
   input  logic                rst,
   exMemIf.dst                 exMem,
   output logic                wbEn,
   output procIsaPkg::regSel_t wbReg,
   output procIsaPkg::word_t   wbData,
   output logic                memWrValid,
   output procIsaPkg::word_t   memWrAddr,
   output procIsaPkg::word_t   memWrData,
   output logic                halted
);
   import procIsaPkg::*;
   import procPipePkg::*;

   localparam int dmemAw = $clog2(`PROC_DMEM_WORDS);

   word_t             dmem [`PROC_DMEM_WORDS];
   logic [dmemAw-1:0] dmemIdx;
   logic              live;     // EX/MEM may still retire
   logic              mwValid;
   pipeCtrl_t         mwCtrl;
   wbSrc_t            mwWbSrc;
   regSel_t           mwRd;
   word_t             mwAlu;
   word_t             mwLoad;
   word_t             mwStoreData;

   assign dmemIdx = exMem.aluResult[dmemAw-1:0];
   assign live    = exMem.valid && !halted;

   always_ff @(posedge clk) begin
      if (live && exMem.ctrl[ctrlMemWrite]) begin
         dmem[dmemIdx] <= exMem.storeData;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         mwValid <= 1'b0;
         mwCtrl  <= '0;
         halted  <= 1'b0;
      end else begin
         mwValid <= live;
         mwCtrl  <= exMem.ctrl;
         if (live && exMem.ctrl[ctrlHalt]) begin
            halted <= 1'b1;      // sticky until reset
         end
      end
   end

   always_ff @(posedge clk) begin
      mwWbSrc     <= exMem.wbSrc;
      mwRd        <= exMem.rd;
      mwAlu       <= exMem.aluResult;
      mwStoreData <= exMem.storeData;
      if (exMem.ctrl[ctrlMemRead]) begin
         mwLoad <= dmem[dmemIdx];
      end
   end

   always_comb begin
      case (mwWbSrc)
         wbMem:   wbData = mwLoad;
         default: wbData = mwAlu;
      endcase
   end

   assign wbEn  = mwValid && mwCtrl[ctrlRegWrite];
   assign wbReg = mwRd;

   // store trace, retired in step with register writes
   assign memWrValid = mwValid && mwCtrl[ctrlMemWrite];
   assign memWrAddr  = mwAlu;
   assign memWrData  = mwStoreData;

endmodule

`default_nettype wire

//--- rtl/proc.sv
// five-stage pipelined processor
`default_nettype none

module proc (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  logic                  progWrEn,
   input  procIsaPkg::imemAddr_t progAddr,
   input  procIsaPkg::word_t     progData,
   output logic                  wbValid,
   output procIsaPkg::regSel_t   wbReg,
   output procIsaPkg::word_t     wbData,
   output logic                  memWrValid,
   output procIsaPkg::word_t     memWrAddr,
   output procIsaPkg::word_t     memWrData,
   output logic                  halted,
   output logic                  err
);
   import procIsaPkg::*;

   logic  ifValid;
   word_t ifInst;
   word_t ifPc;
   logic  stall;
   logic  redirect;
   word_t redirectPc;
   logic  wbEn;

   decExIf decExBus ();
   exMemIf exMemBus ();

   fetchStage fetch (
      .clk(clk), .rst(rst), .run(run),
      .progWrEn(progWrEn), .progAddr(progAddr), .progData(progData),
      .stall(stall), .halted(halted), .redirect(redirect), .redirectPc(redirectPc),
      .ifValid(ifValid), .ifInst(ifInst), .ifPc(ifPc)
   );

   decodeStage decode (
      .clk(clk), .rst(rst), .ifValid(ifValid), .ifInst(ifInst), .ifPc(ifPc),
      .redirect(redirect), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
      .stall(stall), .err(err), .decEx(decExBus.src)
   );

   executeStage execute (
      .clk(clk), .rst(rst), .decEx(decExBus.dst), .exMem(exMemBus.src),
      .redirect(redirect), .redirectPc(redirectPc)
   );

   memWbStage memWb (
      .clk(clk), .rst(rst), .exMem(exMemBus.dst),
      .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
      .memWrValid(memWrValid), .memWrAddr(memWrAddr), .memWrData(memWrData),
      .halted(halted)
   );

   assign wbValid = wbEn;   // one pulse per retired register write

endmodule

`default_nettype wire

//--- tests/procChk.sv
// pipeline rule assertions
`default_nettype none

module procChk (
   input logic clk,
   input logic rst,
   input logic redirect,
   input logic stall,
   input logic ifIdValid,
   input logic idExValid,
   input logic wbValid,
   input logic memWrValid,
   input logic halted
);
   timeunit 1ns;
   timeprecision 100ps;

   // taken branch squashes both younger slots
   flushYounger: assert property (@(posedge clk) disable iff (rst)
      redirect |=> !ifIdValid && !idExValid)
      else $error("redirect left a younger instruction valid in IF/ID or ID/EX");

   quietAfterHalt: assert property (@(posedge clk) disable iff (rst)
      halted |-> !wbValid && !memWrValid)
      else $error("register write or store retired after halted");

   noStallOnRedirect: assert property (@(posedge clk) disable iff (rst)
      !(stall && redirect))
      else $error("stall and redirect high in the same cycle");

endmodule

`default_nettype wire

//--- tests/procMon.sv
// in-order reference model and trace checker
`default_nettype none
`include "proc_settings.svh"

module procMon (
   input logic                clk,
   input logic                wbValid,
   input procIsaPkg::regSel_t wbReg,
   input procIsaPkg::word_t   wbData,
   input logic                memWrValid,
   input procIsaPkg::word_t   memWrAddr,
   input procIsaPkg::word_t   memWrData,
   input logic                err
);
   timeunit 1ns;
   timeprecision 100ps;
   import procIsaPkg::*;

   localparam int progLen = 32;

   bit    active;
   bit    kindQ [$];    // 0 register write, 1 store
   word_t keyQ [$];     // register index or store address
   word_t dataQ [$];
   int    testErrs;
   int    errSeen;
   int    errExpected;
   bit    modelHalted;

   function automatic string kindName(bit kind);
      return kind ? "store to address " : "write to r";
   endfunction

   task automatic queueEvent(input bit kind, input word_t key, input word_t data);
      kindQ.push_back(kind);
      keyQ.push_back(key);
      dataQ.push_back(data);
   endtask

   // next retired event must match the head of the model trace
   task automatic checkEvent(input bit kind, input word_t key, input word_t data);
      if (kindQ.size() == 0) begin
         $display("extra %s%0h retired at %0d ns beyond the model trace",
                  kindName(kind), key, $time);
         testErrs++;
      end else begin
         if (kindQ[0] != kind || keyQ[0] != key || dataQ[0] != data) begin
            $display("Fail %0d ns: %s%0h = %h, model expects %s%0h = %h", $time,
                     kindName(kind), key, data, kindName(kindQ[0]), keyQ[0], dataQ[0]);
            testErrs++;
         end
         kindQ.pop_front();
         keyQ.pop_front();
         dataQ.pop_front();
      end
   endtask

   // runs the whole program up front and keeps the expected trace
   task automatic startTest(input word_t prog [progLen], input int bound);
      word_t   regs [`PROC_REG_CNT];
      word_t   mem [`PROC_DMEM_WORDS];
      word_t   pc;
      word_t   inst;
      word_t   imm6;
      word_t   imm9;
      word_t   addr;
      word_t   res;
      opcode_t op;
      regSel_t rd;
      regSel_t rs;
      regSel_t rt;
      bit      wr;
      kindQ.delete();
      keyQ.delete();
      dataQ.delete();
      foreach (regs[i]) begin
         regs[i] = '0;   // register file clears on reset
      end
      foreach (mem[i]) begin
         mem[i] = '0;
      end
      pc          = '0;
      modelHalted = 1'b0;
      errExpected = 0;
      errSeen     = 0;
      testErrs    = 0;
      for (int n = 0; n < bound && !modelHalted; n++) begin
         inst = (pc[8:6] == 3'b000) ? prog[pc[5:1]] : '0;   // padding reads as NOP
         op   = opcode_t'(inst[15:12]);
         rd   = inst[11:9];
         rs   = inst[8:6];
         rt   = inst[5:3];
         imm6 = {{10{inst[5]}}, inst[5:0]};
         imm9 = {{7{inst[8]}}, inst[8:0]};
         addr = regs[rs] + imm6;
         pc   = pc + 16'd2;
         wr   = op inside {opAdd, opSub, opAnd, opXor, opAddi, opLdi, opLd};
         res  = '0;
         case (op)
            opAdd:  res = regs[rs] + regs[rt];
            opSub:  res = regs[rs] - regs[rt];
            opAnd:  res = regs[rs] & regs[rt];
            opXor:  res = regs[rs] ^ regs[rt];
            opAddi: res = addr;
            opLdi:  res = imm9;
            opLd:   res = mem[addr[7:0]];
            opSt: begin
               mem[addr[7:0]] = regs[rd];
               queueEvent(1'b1, addr, regs[rd]);
            end
            opBeqz: begin
               if (regs[rd] == '0) begin
                  pc = pc + (imm9 << 1);
               end
            end
            opHalt: modelHalted = 1'b1;
            opNop:  ;
            default: errExpected++;   // illegal opcode acts as a no-op
         endcase
         if (wr) begin
            regs[rd] = res;
            queueEvent(1'b0, word_t'(rd), res);
         end
      end
      active = 1'b1;
   endtask

   task automatic endTest(output int errs);
      if (!modelHalted) begin
         $display("model found no HALT within the instruction bound");
         testErrs++;
      end
      if (kindQ.size() != 0) begin
         $display("%0d expected events never retired", kindQ.size());
         testErrs++;
      end
      if (errSeen != errExpected) begin
         $display("Fail %0d ns: err high in %0d cycles, model expects %0d illegal opcodes",
                  $time, errSeen, errExpected);
         testErrs++;
      end
      active = 1'b0;
      errs   = testErrs;
   endtask

   // outputs only move on the rising edge
   always @(negedge clk) begin
      if (active) begin
         if (wbValid) begin
            checkEvent(1'b0, word_t'(wbReg), wbData);
         end
         if (memWrValid) begin
            checkEvent(1'b1, memWrAddr, memWrData);
         end
         if (err) begin
            errSeen++;
         end
      end
   end

endmodule

`default_nettype wire

//--- tests/procTb.sv
// processor testbench
`default_nettype none

module procTb;
   timeunit 1ns;
   timeprecision 100ps;
   import procIsaPkg::*;

   localparam int testCnt = 6;
   localparam int progLen = 32;
   localparam int clkHalf = 4;

   logic      clk;
   logic      rst;
   logic      run;
   logic      progWrEn;
   imemAddr_t progAddr;
   word_t     progData;
   logic      wbValid;
   regSel_t   wbReg;
   word_t     wbData;
   logic      memWrValid;
   word_t     memWrAddr;
   word_t     memWrData;
   logic      halted;
   logic      err;

   // test table with unused words left as NOP
   string testName [testCnt];
   word_t testProg [testCnt][progLen];
   int    testBound [testCnt];
   int    fillCnt [testCnt];

   word_t curProg [progLen];
   int    passCnt;
   int    failCnt;
   int    limitNs;

   proc UUT (.*);

   procMon mon (.*);

   bind proc procChk chk (
      .clk(clk),
      .rst(rst),
      .redirect(redirect),
      .stall(stall),
      .ifIdValid(decode.ifIdValid),
      .idExValid(decExBus.valid),
      .wbValid(wbValid),
      .memWrValid(memWrValid),
      .halted(halted)
   );

   function automatic word_t encodeReg(opcode_t op, int rd, int rs, int rt);
      return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
   endfunction

   function automatic word_t encodeImm6(opcode_t op, int rd, int rs, int imm);
      return {op, rd[2:0], rs[2:0], imm[5:0]};
   endfunction

   function automatic word_t encodeImm9(opcode_t op, int rd, int imm);
      return {op, rd[2:0], imm[8:0]};
   endfunction

   function automatic logic [31:0] xorshift32(logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // one ALU or immediate instruction from a random word
   function automatic word_t randomAluWord(logic [31:0] r);
      int rd;
      int rs;
      int rt;
      int imm;
      rd  = int'(r[10:8]);
      rs  = int'(r[13:11]);
      rt  = int'(r[16:14]);
      imm = int'(r[25:17]);
      case (int'(r[7:0]) % 6)
         0: return encodeReg(opAdd, rd, rs, rt);
         1: return encodeReg(opSub, rd, rs, rt);
         2: return encodeReg(opAnd, rd, rs, rt);
         3: return encodeReg(opXor, rd, rs, rt);
         4: return encodeImm6(opAddi, rd, rs, imm);
         default: return encodeImm9(opLdi, rd, imm);
      endcase
   endfunction

   task automatic appendWord(int t, word_t w);
      testProg[t][fillCnt[t]] = w;
      fillCnt[t]++;
   endtask

   task automatic buildTests();
      logic [31:0] rnd;
      foreach (testProg[t, i]) begin
         testProg[t][i] = '0;
      end
      foreach (fillCnt[t]) begin
         fillCnt[t] = 0;
      end

      testName[0]  = "alu and immediates";
      testBound[0] = 16;
      appendWord(0, encodeImm9(opLdi, 1, 5));
      appendWord(0, encodeImm9(opLdi, 2, -3));
      appendWord(0, encodeReg(opAdd, 3, 1, 2));   // back to back dependency stalls
      appendWord(0, encodeReg(opSub, 4, 3, 1));
      appendWord(0, encodeReg(opAnd, 5, 4, 1));
      appendWord(0, encodeReg(opXor, 6, 5, 2));
      appendWord(0, encodeImm6(opAddi, 7, 6, -7));
      appendWord(0, encodeImm6(opAddi, 0, 7, 31));
      appendWord(0, encodeImm9(opHalt, 0, 0));

      testName[1]  = "store then load";
      testBound[1] = 16;
      appendWord(1, encodeImm9(opLdi, 1, 64));
      appendWord(1, encodeImm9(opLdi, 2, 171));
      appendWord(1, encodeImm6(opSt, 2, 1, 3));
      appendWord(1, encodeImm6(opLd, 3, 1, 3));
      appendWord(1, encodeImm6(opAddi, 4, 3, 1));
      appendWord(1, encodeImm6(opSt, 4, 1, -4));
      appendWord(1, encodeImm6(opLd, 5, 1, -4));
      appendWord(1, encodeReg(opAdd, 6, 5, 3));
      appendWord(1, encodeImm9(opHalt, 0, 0));

      testName[2]  = "branches and countdown loop";
      testBound[2] = 32;
      appendWord(2, encodeImm9(opLdi, 7, 5));
      appendWord(2, encodeImm9(opBeqz, 1, 2));    // skips the next two
      appendWord(2, encodeReg(opAdd, 2, 7, 7));   // reads r7 while the branch resolves
      appendWord(2, encodeImm9(opLdi, 3, 8));
      appendWord(2, encodeImm9(opLdi, 4, 3));
      appendWord(2, encodeImm6(opAddi, 5, 5, 2)); // loop top
      appendWord(2, encodeImm6(opAddi, 4, 4, -1));
      appendWord(2, encodeImm9(opBeqz, 4, 2));    // exit to HALT
      appendWord(2, encodeImm9(opLdi, 6, 0));
      appendWord(2, encodeImm9(opBeqz, 6, -5));   // back to loop top
      appendWord(2, encodeImm9(opHalt, 0, 0));

      testName[3]  = "halt stops retirement";
      testBound[3] = 8;
      appendWord(3, encodeImm9(opLdi, 1, 9));
      appendWord(3, encodeImm6(opSt, 1, 1, 0));
      appendWord(3, encodeImm9(opHalt, 0, 0));
      appendWord(3, encodeImm9(opLdi, 2, 1));
      appendWord(3, encodeImm6(opSt, 1, 1, 1));
      appendWord(3, encodeReg(opAdd, 3, 1, 1));
      appendWord(3, encodeImm9(opHalt, 0, 0));

      testName[4]  = "random alu program";
      testBound[4] = 32;
      rnd = 32'd65;
      for (int n = 0; n < 20; n++) begin
         rnd = xorshift32(rnd);
         appendWord(4, randomAluWord(rnd));
      end
      appendWord(4, encodeImm9(opHalt, 0, 0));

      testName[5]  = "illegal opcodes";
      testBound[5] = 12;
      appendWord(5, encodeImm9(opLdi, 1, 4));
      appendWord(5, 16'ha000);
      appendWord(5, encodeImm6(opAddi, 2, 1, 1));
      appendWord(5, 16'hc3ff);
      appendWord(5, encodeReg(opAdd, 3, 2, 1));
      appendWord(5, encodeImm9(opHalt, 0, 0));
   endtask

   task automatic loadProgram();
      for (int i = 0; i < progLen; i++) begin
         @(negedge clk);
         progWrEn = 1'b1;
         progAddr = imemAddr_t'(i);
         progData = curProg[i];
      end
      @(negedge clk);
      progWrEn = 1'b0;
   endtask

   task automatic runTest(int t);
      int errs;
      @(negedge clk);
      rst = 1'b1;
      run = 1'b0;
      repeat (8) @(negedge clk);
      rst = 1'b0;
      foreach (curProg[i]) begin
         curProg[i] = testProg[t][i];
      end
      loadProgram();
      @(posedge clk);
      mon.startTest(curProg, testBound[t]);
      @(negedge clk);
      run = 1'b1;
      while (!halted) begin
         @(negedge clk);
      end
      run = 1'b0;
      repeat (4) @(negedge clk);   // room for stray events after halt
      @(posedge clk);
      mon.endTest(errs);
      if (errs == 0) begin
         passCnt++;
         $display("test %0d (%s) pass", t, testName[t]);
      end else begin
         failCnt++;
         $display("test %0d (%s) fail, %0d errors", t, testName[t], errs);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #(clkHalf) clk = ~clk;
   end

   initial begin
      rst      = 1'b1;
      run      = 1'b0;
      progWrEn = 1'b0;
      progAddr = '0;
      progData = '0;
      passCnt  = 0;
      failCnt  = 0;
      buildTests();
      limitNs = 0;
      for (int t = 0; t < testCnt; t++) begin
         limitNs += (testBound[t] * 8 + 8 + progLen + 16) * 2 * clkHalf;
      end
      fork
         begin
            #(limitNs);
            $display("watchdog: run did not finish within %0d ns", limitNs);
            $display("*** TEST FAILED ***");
            $finish;
         end
      join_none
      for (int t = 0; t < testCnt; t++) begin
         runTest(t);
      end
      $display("tests passed: %0d, failed: %0d", passCnt, failCnt);
      if (failCnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/procIsaPkg.sv
rtl/procPipePkg.sv
rtl/procStageIf.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memWbStage.sv
rtl/proc.sv
tests/procChk.sv
tests/procMon.sv
tests/procTb.sv

//--- run.sh
#!/bin/sh
# build and run the processor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module procTb -f compile.f -o procSim

# pipe status is tee's, the log search decides the verdict
./obj_dir/procSim | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi
